// File: hdl/connect4_pkg.sv
package connect4_pkg;

	//////////////////////////////
	// Board geometry
	//////////////////////////////

	localparam int NUM_COLUMNS = 7;
	localparam int NUM_ROWS    = 7;
	localparam int WIN_LENGTH  = 4;
	localparam int NUM_CELLS   = NUM_COLUMNS * NUM_ROWS;

	// APB byte addresses
	localparam logic [7:0] ADDR_MOVE     = 8'h00;
	localparam logic [7:0] ADDR_STATUS   = 8'h04;
	localparam logic [7:0] ADDR_RESTART  = 8'h08;
	localparam logic [7:0] ADDR_ROW_BASE = 8'h10;

	typedef logic [2:0] column_t;
	typedef logic [2:0] row_t;
	typedef logic [1:0] player_t;

	// Cell (r, c) at bits 2*(7r + c) +: 2, row 0 at the bottom
	typedef logic [2*NUM_CELLS-1:0] board_t;

	localparam player_t PLAYER_NONE = 2'd0;
	localparam player_t PLAYER_ONE  = 2'd1;
	localparam player_t PLAYER_TWO  = 2'd2;

	typedef struct packed {
		column_t column;
		row_t    row;
		player_t player;
	} move_t;

	typedef enum logic [1:0] {IDLE, PLACE, CHECK} game_state_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_request_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_response_t;

endpackage

// File: hdl/column_heights.sv
module column_heights (
	input  logic                  clock,
	input  logic                  reset_n,
	input  connect4_pkg::column_t requested_column,
	input  logic                  place_valid,
	input  connect4_pkg::move_t   place_move,
	input  logic                  clear,
	output connect4_pkg::row_t    landing_row,
	output logic                  column_full
);
	import connect4_pkg::*;

	// Pieces stacked in each column, also the next free row
	row_t fill_level [NUM_COLUMNS];

	always_ff @(posedge clock) begin
		if (!reset_n || clear) begin
			for (int c = 0; c < NUM_COLUMNS; c++) begin
				fill_level[c] <= '0;
			end
		end else if (place_valid) begin
			for (int c = 0; c < NUM_COLUMNS; c++) begin
				if (place_move.column == column_t'(c)) begin
					fill_level[c] <= fill_level[c] + row_t'(1);
				end
			end
		end
	end

	// Column 7 matches nothing and reads as empty
	always_comb begin
		landing_row = '0;
		column_full = 1'b0;
		for (int c = 0; c < NUM_COLUMNS; c++) begin
			if (requested_column == column_t'(c)) begin
				landing_row = fill_level[c];
				column_full = fill_level[c] == row_t'(NUM_ROWS);
			end
		end
	end

endmodule

// File: hdl/board_store.sv
module board_store (
	input  logic                clock,
	input  logic                reset_n,
	input  logic                place_valid,
	input  connect4_pkg::move_t place_move,
	input  logic                clear,
	output connect4_pkg::board_t board
);
	import connect4_pkg::*;

	// Lowest bit of the addressed cell
	logic [6:0] cell_bit;

	assign cell_bit = 7'(2 * (NUM_COLUMNS * place_move.row + place_move.column));

	always_ff @(posedge clock) begin
		if (!reset_n || clear) begin
			board <= '0;
		end else if (place_valid) begin
			board[cell_bit +: 2] <= place_move.player;
		end
	end

endmodule

// File: hdl/win_checker.sv
module win_checker (
	input  connect4_pkg::board_t  board,
	output connect4_pkg::player_t winner
);
	import connect4_pkg::*;

	function automatic player_t cell_at(board_t b, int r, int c);
		return b[2*(NUM_COLUMNS*r + c) +: 2];
	endfunction

	// Owner of the run from (r, c) along (dr, dc), empty if mixed or off the board
	function automatic player_t run_owner(board_t b, int r, int c, int dr, int dc);
		player_t owner;
		int      last_r;
		int      last_c;
		owner  = PLAYER_NONE;
		last_r = r + dr * (WIN_LENGTH - 1);
		last_c = c + dc * (WIN_LENGTH - 1);
		if (last_r >= 0 && last_r < NUM_ROWS && last_c >= 0 && last_c < NUM_COLUMNS) begin
			owner = cell_at(b, r, c);
			for (int k = 1; k < WIN_LENGTH; k++) begin
				if (cell_at(b, r + dr*k, c + dc*k) != owner) begin
					owner = PLAYER_NONE;
				end
			end
		end
		return owner;
	endfunction

	//////////////////////////////
	// Line search
	//////////////////////////////

	always_comb begin
		player_t found;
		winner = PLAYER_NONE;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLUMNS; c++) begin
				// Horizontal, vertical, rising and falling diagonals
				found = run_owner(board, r, c, 0, 1);
				if (found != PLAYER_NONE) winner = found;
				found = run_owner(board, r, c, 1, 0);
				if (found != PLAYER_NONE) winner = found;
				found = run_owner(board, r, c, 1, 1);
				if (found != PLAYER_NONE) winner = found;
				found = run_owner(board, r, c, 1, -1);
				if (found != PLAYER_NONE) winner = found;
			end
		end
	end

endmodule

// File: hdl/game_control.sv
module game_control (
	input  logic                       clock,
	input  logic                       reset_n,
	input  connect4_pkg::apb_request_t  apb_request,
	output connect4_pkg::apb_response_t apb_response,
	input  connect4_pkg::row_t          landing_row,
	input  logic                       column_full,
	input  connect4_pkg::board_t        board,
	input  connect4_pkg::player_t       winner,
	output connect4_pkg::column_t       requested_column,
	output logic                       place_valid,
	output connect4_pkg::move_t         place_move,
	output logic                       clear
);
	import connect4_pkg::*;

	game_state_t state;
	player_t     turn;
	player_t     winner_q;
	logic        game_over;
	logic [5:0]  piece_count;

	logic        access;
	logic        move_hit;
	logic        status_hit;
	logic        restart_hit;
	logic        row_hit;
	logic        move_ok;
	logic [7:0]  row_offset;
	row_t        row_index;
	logic [2*NUM_COLUMNS-1:0] row_bits;
	logic [31:0] read_data;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	assign access      = apb_request.psel && apb_request.penable;
	assign move_hit    = apb_request.pwrite && apb_request.paddr == ADDR_MOVE;
	assign restart_hit = apb_request.pwrite && apb_request.paddr == ADDR_RESTART;
	assign status_hit  = !apb_request.pwrite && apb_request.paddr == ADDR_STATUS;

	// Rows are word aligned from ADDR_ROW_BASE
	assign row_offset = apb_request.paddr - ADDR_ROW_BASE;
	assign row_index  = row_offset[4:2];
	assign row_hit    = !apb_request.pwrite && apb_request.paddr >= ADDR_ROW_BASE &&
		row_offset[1:0] == 2'b00 && row_offset[7:2] < NUM_ROWS;

	assign requested_column = apb_request.pwdata[2:0];

	assign move_ok = requested_column < NUM_COLUMNS && !column_full && !game_over &&
		piece_count != 6'(NUM_CELLS);

	assign clear       = access && restart_hit && state == IDLE;
	assign place_valid = state == PLACE;

	//////////////////////////////
	// Move sequencing
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset_n || clear) begin
			state       <= IDLE;
			turn        <= PLAYER_ONE;
			winner_q    <= PLAYER_NONE;
			game_over   <= 1'b0;
			piece_count <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (access && move_hit && move_ok) begin
						state <= PLACE;
					end
				end
				PLACE: begin
					state <= CHECK;
				end
				CHECK: begin
					// Board already holds the new piece here
					state       <= IDLE;
					winner_q    <= winner;
					game_over   <= winner != PLAYER_NONE ||
						piece_count + 6'd1 == 6'(NUM_CELLS);
					piece_count <= piece_count + 6'd1;
					turn        <= (turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Piece to drop, captured when the move is accepted
	always_ff @(posedge clock) begin
		if (state == IDLE) begin
			place_move <= '{column: requested_column, row: landing_row, player: turn};
		end
	end

	//////////////////////////////
	// Read data and response
	//////////////////////////////

	always_comb begin
		row_bits = '0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (row_index == row_t'(r)) begin
				row_bits = board[r*2*NUM_COLUMNS +: 2*NUM_COLUMNS];
			end
		end
	end

	always_comb begin
		read_data = '0;
		if (status_hit) begin
			read_data = {21'b0, piece_count, game_over, winner_q, turn};
		end else if (row_hit) begin
			read_data = {18'b0, row_bits};
		end
	end

	always_comb begin
		apb_response = '0;
		if (access) begin
			case (state)
				IDLE: begin
					if (move_hit) begin
						// Accepted moves wait for PLACE and CHECK
						apb_response.pready  = !move_ok;
						apb_response.pslverr = !move_ok;
					end else begin
						apb_response.pready  = 1'b1;
						apb_response.pslverr = !(status_hit || restart_hit || row_hit);
						apb_response.prdata  = read_data;
					end
				end
				CHECK: begin
					apb_response.pready = 1'b1;
				end
				default: begin
					apb_response.pready = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: hdl/connect4_top.sv
module connect4_top (
	input  logic                       clock,
	input  logic                       reset_n,
	input  connect4_pkg::apb_request_t  apb_request,
	output connect4_pkg::apb_response_t apb_response
);
	import connect4_pkg::*;

	column_t requested_column;
	row_t    landing_row;
	logic    column_full;
	logic    place_valid;
	move_t   place_move;
	logic    clear;
	board_t  board;
	player_t winner;

	game_control control_i (
		.clock            (clock),
		.reset_n          (reset_n),
		.apb_request      (apb_request),
		.apb_response     (apb_response),
		.landing_row      (landing_row),
		.column_full      (column_full),
		.board            (board),
		.winner           (winner),
		.requested_column (requested_column),
		.place_valid      (place_valid),
		.place_move       (place_move),
		.clear            (clear)
	);

	column_heights heights_i (
		.clock            (clock),
		.reset_n          (reset_n),
		.requested_column (requested_column),
		.place_valid      (place_valid),
		.place_move       (place_move),
		.clear            (clear),
		.landing_row      (landing_row),
		.column_full      (column_full)
	);

	board_store store_i (
		.clock       (clock),
		.reset_n     (reset_n),
		.place_valid (place_valid),
		.place_move  (place_move),
		.clear       (clear),
		.board       (board)
	);

	win_checker checker_i (
		.board  (board),
		.winner (winner)
	);

endmodule

// File: testbench/connect4_assertions.sv
module connect4_assertions (
	input logic                        clock,
	input logic                        reset_n,
	input connect4_pkg::apb_request_t  apb_request,
	input connect4_pkg::apb_response_t apb_response,
	input logic                        place_valid
);
	import connect4_pkg::*;

	// Ready only in an access phase
	assert property (@(posedge clock) disable iff (!reset_n)
		apb_response.pready |-> apb_request.psel && apb_request.penable)
		else $error("pready raised outside an APB access phase");

	assert property (@(posedge clock) disable iff (!reset_n)
		apb_response.pslverr |-> apb_response.pready)
		else $error("pslverr raised without pready");

	// A piece drops only right after a MOVE write that was held waiting
	assert property (@(posedge clock) disable iff (!reset_n)
		place_valid |-> $past(apb_request.psel && apb_request.penable &&
			apb_request.pwrite && apb_request.paddr == ADDR_MOVE &&
			!apb_response.pready))
		else $error("place_valid raised without a pending MOVE write");

endmodule

bind game_control connect4_assertions assertions_i (
	.clock        (clock),
	.reset_n      (reset_n),
	.apb_request  (apb_request),
	.apb_response (apb_response),
	.place_valid  (place_valid)
);

// File: testbench/connect4_tb.sv
module connect4_tb;
	import connect4_pkg::*;

	logic          clock;
	logic          reset_n;
	apb_request_t  apb_request;
	apb_response_t apb_response;

	int cycle_count = 0;
	int cycle_limit = 0;

	// Trace columns, one entry per transfer
	logic        trace_write [$];
	logic [7:0]  trace_addr  [$];
	logic [31:0] trace_wdata [$];
	logic [31:0] trace_rdata [$];
	logic        trace_err   [$];

	connect4_top dut_i (
		.clock        (clock),
		.reset_n      (reset_n),
		.apb_request  (apb_request),
		.apb_response (apb_response)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	task automatic report_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: run still going after %0d cycles", cycle_count);
			report_failure();
		end
	end

	//////////////////////////////
	// Trace reader
	//////////////////////////////

	task automatic read_trace();
		int          fd;
		string       line;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] err;
		fd = $fopen("testbench/connect4_trace.txt", "r");
		assert (fd != 0) else begin
			$display("Could not open the trace file");
			report_failure();
		end
		while ($fgets(line, fd) != 0) begin
			// Comment lines fail to parse as five fields
			if ($sscanf(line, "%c %h %h %h %h", op, addr, wdata, rdata, err) == 5 &&
				(op == "R" || op == "W")) begin
				trace_write.push_back(op == "W");
				trace_addr.push_back(addr[7:0]);
				trace_wdata.push_back(wdata);
				trace_rdata.push_back(rdata);
				trace_err.push_back(err[0]);
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////
	// APB driver and checks
	//////////////////////////////

	task automatic apb_transfer(input int n);
		logic [31:0] rdata;
		logic        err;
		@(posedge clock);
		apb_request.psel    <= 1'b1;
		apb_request.penable <= 1'b0;
		apb_request.pwrite  <= trace_write[n];
		apb_request.paddr   <= trace_addr[n];
		apb_request.pwdata  <= trace_wdata[n];
		@(posedge clock);
		apb_request.penable <= 1'b1;
		// Sampled mid-cycle; the next rising edge ends the transfer
		@(negedge clock);
		while (!apb_response.pready) begin
			@(negedge clock);
		end
		rdata = apb_response.prdata;
		err   = apb_response.pslverr;
		@(posedge clock);
		apb_request <= '0;
		assert (err == trace_err[n]) else begin
			$display("Mismatch pslverr in transfer %0d: expected %h, got %h",
				n, trace_err[n], err);
			report_failure();
		end
		if (!trace_write[n]) begin
			assert (rdata == trace_rdata[n]) else begin
				$display("Mismatch prdata in transfer %0d: expected %h, got %h",
					n, trace_rdata[n], rdata);
				report_failure();
			end
		end
	endtask

	initial begin
		apb_request = '0;
		reset_n     = 1'b0;
		read_trace();
		assert (trace_write.size() > 0) else begin
			$display("Trace file holds no transfers");
			report_failure();
		end
		cycle_limit = 10 * trace_write.size() + 100;
		repeat (10) begin
			@(posedge clock);
		end
		reset_n <= 1'b1;
		for (int n = 0; n < trace_write.size(); n++) begin
			apb_transfer(n);
		end
		$display("Completed %0d trace transfers", trace_write.size());
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: connect4.f
hdl/connect4_pkg.sv
hdl/column_heights.sv
hdl/board_store.sv
hdl/win_checker.sv
hdl/game_control.sv
hdl/connect4_top.sv
testbench/connect4_assertions.sv
testbench/connect4_tb.sv

// File: Makefile
TOOL      = verilator
TOP       = connect4_tb
FILE_LIST = connect4.f
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/connect4_trace.txt
# op (R or W), address, write data, expected read data, expected pslverr (all hex)
# Read data is compared on reads only; STATUS is count<<5 | game_over<<4 | winner<<2 | turn
W 00 00000003 00000000 0
W 00 00000003 00000000 0
W 00 00000003 00000000 0
W 00 00000003 00000000 0
W 00 00000003 00000000 0
W 00 00000003 00000000 0
W 00 00000003 00000000 0
W 00 00000003 00000000 1
R 10 00000000 00000040 0
R 14 00000000 00000080 0
R 18 00000000 00000040 0
R 04 00000000 000000e2 0
W 00 00000007 00000000 1
R 0c 00000000 00000000 1
R 04 00000000 000000e2 0
W 00 00000000 00000000 0
W 00 00000001 00000000 0
W 00 00000000 00000000 0
W 00 00000001 00000000 0
W 00 00000000 00000000 0
W 00 00000001 00000000 0
W 00 00000000 00000000 0
R 04 00000000 000001d9 0
W 00 00000004 00000000 1
W 08 00000000 00000000 0
W 00 00000000 00000000 0
W 00 00000000 00000000 0
W 00 00000001 00000000 0
W 00 00000001 00000000 0
W 00 00000002 00000000 0
W 00 00000002 00000000 0
W 00 00000003 00000000 0
R 04 00000000 000000f6 0
R 10 00000000 00000055 0
W 08 00000000 00000000 0
W 00 00000002 00000000 0
W 00 00000003 00000000 0
W 00 00000001 00000000 0
W 00 00000002 00000000 0
W 00 00000001 00000000 0
W 00 00000001 00000000 0
W 00 00000000 00000000 0
W 00 00000000 00000000 0
W 00 00000000 00000000 0
W 00 00000000 00000000 0
R 04 00000000 00000159 0
W 08 00000000 00000000 0
R 04 00000000 00000001 0
R 10 00000000 00000000 0
R 14 00000000 00000000 0
R 18 00000000 00000000 0
R 1c 00000000 00000000 0
R 20 00000000 00000000 0
R 24 00000000 00000000 0
R 28 00000000 00000000 0
